// File: src/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// primary opcode, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_COP0    = 6'b010000,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} op_e;

	// function field of SPECIAL, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL     = 6'b000000,
		FN_SRL     = 6'b000010,
		FN_SRA     = 6'b000011,
		FN_SLLV    = 6'b000100,
		FN_SRLV    = 6'b000110,
		FN_SRAV    = 6'b000111,
		FN_JR      = 6'b001000,
		FN_JALR    = 6'b001001,
		FN_SYSCALL = 6'b001100,
		FN_ADD     = 6'b100000,
		FN_ADDU    = 6'b100001,
		FN_SUB     = 6'b100010,
		FN_SUBU    = 6'b100011,
		FN_AND     = 6'b100100,
		FN_OR      = 6'b100101,
		FN_XOR     = 6'b100110,
		FN_NOR     = 6'b100111,
		FN_SLT     = 6'b101010,
		FN_SLTU    = 6'b101011
	} funct_e;

	// execute op codes, same numbering as the rest of the core
	typedef enum logic [7:0] {
		ALU_NOP     = 8'b00000000,
		ALU_AND     = 8'b00100100,
		ALU_OR      = 8'b00100101,
		ALU_XOR     = 8'b00100110,
		ALU_NOR     = 8'b00100111,
		ALU_SLL     = 8'b01111100,
		ALU_SRL     = 8'b00000010,
		ALU_SRA     = 8'b00000011,
		ALU_SLT     = 8'b00101010,
		ALU_SLTU    = 8'b00101011,
		ALU_ADD     = 8'b00100000,
		ALU_ADDU    = 8'b00100001,
		ALU_SUB     = 8'b00100010,
		ALU_SUBU    = 8'b00100011,
		ALU_ADDI    = 8'b01010101,
		ALU_ADDIU   = 8'b01010110,
		ALU_J       = 8'b01001111,
		ALU_JAL     = 8'b01010000,
		ALU_JR      = 8'b00001000,
		ALU_JALR    = 8'b00001001,
		ALU_BEQ     = 8'b01010001,
		ALU_BNE     = 8'b01010010,
		ALU_BGTZ    = 8'b01010100,
		ALU_BLEZ    = 8'b01010011,
		ALU_BGEZ    = 8'b01000001,
		ALU_BLTZ    = 8'b01000000,
		ALU_LW      = 8'b11100011,
		ALU_SW      = 8'b11101011,
		ALU_SYSCALL = 8'b00001100,
		ALU_ERET    = 8'b01101011
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alu_sel_e;

	typedef enum logic [3:0] {
		BR_NONE,
		BR_JUMP_IMM,
		BR_JUMP_REG,
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_GEZ,
		BR_LTZ
	} br_kind_e;

	// bit 8 syscall, bit 9 invalid, bit 12 eret
	typedef struct packed {
		logic [18:0] rsvd_hi;
		logic        eret;
		logic [1:0]  rsvd_mid;
		logic        invalid;
		logic        syscall;
		logic [7:0]  rsvd_lo;
	} except_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		logic      wreg;
		reg_addr_t wd;
		logic      rs_read;
		logic      rt_read;
		reg_addr_t rs_addr;
		reg_addr_t rt_addr;
		word_t     imm;
		br_kind_e  br_kind;
		logic      link;
		logic      is_syscall;
		logic      is_eret;
		logic      valid;
	} dec_ctrl_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		word_t     link_addr;
		logic      in_delay_slot;
		word_t     inst;
		except_t   except;
	} ex_bundle_t;

	localparam reg_addr_t LINK_REG   = 5'd31;
	localparam word_t     INST_BYTES = 32'd4;
	localparam word_t     ERET_WORD  = 32'h4200_0018;

endpackage

// File: src/fwd_src_if.sv
`timescale 1ns/1ps

// one later stage that may write the register file
interface fwd_src_if import mips_pkg::*; ();

	logic      wreg;
	reg_addr_t wd;
	word_t     wdata;
	alu_op_e   alu_op;	// lets decode spot a load in flight

	modport src (
		output wreg,
		output wd,
		output wdata,
		output alu_op
	);

	modport sink (
		input wreg,
		input wd,
		input wdata,
		input alu_op
	);

endinterface

// File: src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import mips_pkg::*; (
	input  word_t     inst_i,
	input  word_t     pc_i,
	output dec_ctrl_t ctrl_o,
	output word_t     link_addr_o
);

	localparam reg_addr_t RT_BLTZ = 5'b00000;
	localparam reg_addr_t RT_BGEZ = 5'b00001;

	op_e       op;
	funct_e    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	reg_addr_t shamt;
	dec_ctrl_t ctrl;

	assign op    = op_e'(inst_i[31:26]);
	assign funct = funct_e'(inst_i[5:0]);
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign shamt = inst_i[10:6];

	// rd <= rs op rt
	function automatic dec_ctrl_t reg_reg(dec_ctrl_t c, alu_op_e aop, alu_sel_e sel);
		c.wreg    = 1'b1;
		c.alu_op  = aop;
		c.alu_sel = sel;
		c.rs_read = 1'b1;
		c.rt_read = 1'b1;
		c.valid   = 1'b1;
		return c;
	endfunction

	// rt <= rs op imm
	function automatic dec_ctrl_t reg_imm(dec_ctrl_t c, alu_op_e aop, alu_sel_e sel,
			word_t imm);
		c.wreg    = 1'b1;
		c.alu_op  = aop;
		c.alu_sel = sel;
		c.rs_read = 1'b1;
		c.wd      = c.rt_addr;
		c.imm     = imm;
		c.valid   = 1'b1;
		return c;
	endfunction

	// shamt goes out on operand 1, rt on operand 2
	function automatic dec_ctrl_t shift_imm(dec_ctrl_t c, alu_op_e aop, reg_addr_t sa);
		c.wreg    = 1'b1;
		c.alu_op  = aop;
		c.alu_sel = SEL_SHIFT;
		c.rt_read = 1'b1;
		c.imm     = {27'd0, sa};
		c.valid   = 1'b1;
		return c;
	endfunction

	function automatic dec_ctrl_t jump_br(dec_ctrl_t c, alu_op_e aop, br_kind_e kind,
			logic use_rs, logic use_rt);
		c.alu_op  = aop;
		c.alu_sel = SEL_JUMP_BRANCH;
		c.br_kind = kind;
		c.rs_read = use_rs;
		c.rt_read = use_rt;
		c.valid   = 1'b1;
		return c;
	endfunction

	//////////////////////////////////////////////////
	// main decode
	//////////////////////////////////////////////////
	always_comb begin
		ctrl         = '0;
		ctrl.alu_op  = ALU_NOP;
		ctrl.alu_sel = SEL_NOP;
		ctrl.br_kind = BR_NONE;
		ctrl.wd      = rd;
		ctrl.rs_addr = rs;
		ctrl.rt_addr = rt;
		case (op)
			OP_SPECIAL: begin
				if (shamt == 5'd0) begin
					case (funct)
						FN_AND:  ctrl = reg_reg(ctrl, ALU_AND, SEL_LOGIC);
						FN_OR:   ctrl = reg_reg(ctrl, ALU_OR, SEL_LOGIC);
						FN_XOR:  ctrl = reg_reg(ctrl, ALU_XOR, SEL_LOGIC);
						FN_NOR:  ctrl = reg_reg(ctrl, ALU_NOR, SEL_LOGIC);
						FN_SLLV: ctrl = reg_reg(ctrl, ALU_SLL, SEL_SHIFT);	// variable shifts
						FN_SRLV: ctrl = reg_reg(ctrl, ALU_SRL, SEL_SHIFT);
						FN_SRAV: ctrl = reg_reg(ctrl, ALU_SRA, SEL_SHIFT);
						FN_SLT:  ctrl = reg_reg(ctrl, ALU_SLT, SEL_ARITH);
						FN_SLTU: ctrl = reg_reg(ctrl, ALU_SLTU, SEL_ARITH);
						FN_ADD:  ctrl = reg_reg(ctrl, ALU_ADD, SEL_ARITH);
						FN_ADDU: ctrl = reg_reg(ctrl, ALU_ADDU, SEL_ARITH);
						FN_SUB:  ctrl = reg_reg(ctrl, ALU_SUB, SEL_ARITH);
						FN_SUBU: ctrl = reg_reg(ctrl, ALU_SUBU, SEL_ARITH);
						FN_JR:   ctrl = jump_br(ctrl, ALU_JR, BR_JUMP_REG, 1'b1, 1'b0);
						FN_JALR: begin
							ctrl      = jump_br(ctrl, ALU_JALR, BR_JUMP_REG, 1'b1, 1'b0);
							ctrl.wreg = 1'b1;	// link into rd
							ctrl.link = 1'b1;
						end
						default: ;
					endcase
				end
				if (rs == 5'd0) begin
					case (funct)
						FN_SLL: ctrl = shift_imm(ctrl, ALU_SLL, shamt);
						FN_SRL: ctrl = shift_imm(ctrl, ALU_SRL, shamt);
						FN_SRA: ctrl = shift_imm(ctrl, ALU_SRA, shamt);
						default: ;
					endcase
				end
				if (funct == FN_SYSCALL) begin
					ctrl.alu_op     = ALU_SYSCALL;
					ctrl.is_syscall = 1'b1;
					ctrl.valid      = 1'b1;
				end
			end
			OP_REGIMM: begin
				case (rt)
					RT_BLTZ: ctrl = jump_br(ctrl, ALU_BLTZ, BR_LTZ, 1'b1, 1'b0);
					RT_BGEZ: ctrl = jump_br(ctrl, ALU_BGEZ, BR_GEZ, 1'b1, 1'b0);
					default: ;
				endcase
			end
			OP_J:     ctrl = jump_br(ctrl, ALU_J, BR_JUMP_IMM, 1'b0, 1'b0);
			OP_JAL: begin
				ctrl      = jump_br(ctrl, ALU_JAL, BR_JUMP_IMM, 1'b0, 1'b0);
				ctrl.wreg = 1'b1;
				ctrl.wd   = LINK_REG;
				ctrl.link = 1'b1;
			end
			OP_BEQ:   ctrl = jump_br(ctrl, ALU_BEQ, BR_EQ, 1'b1, 1'b1);
			OP_BNE:   ctrl = jump_br(ctrl, ALU_BNE, BR_NE, 1'b1, 1'b1);
			OP_BLEZ:  ctrl = jump_br(ctrl, ALU_BLEZ, BR_LEZ, 1'b1, 1'b0);
			OP_BGTZ:  ctrl = jump_br(ctrl, ALU_BGTZ, BR_GTZ, 1'b1, 1'b0);
			OP_ADDI:  ctrl = reg_imm(ctrl, ALU_ADDI, SEL_ARITH, {{16{inst_i[15]}}, inst_i[15:0]});
			OP_ADDIU: ctrl = reg_imm(ctrl, ALU_ADDIU, SEL_ARITH, {{16{inst_i[15]}}, inst_i[15:0]});
			OP_SLTI:  ctrl = reg_imm(ctrl, ALU_SLT, SEL_ARITH, {{16{inst_i[15]}}, inst_i[15:0]});
			OP_SLTIU: ctrl = reg_imm(ctrl, ALU_SLTU, SEL_ARITH, {{16{inst_i[15]}}, inst_i[15:0]});
			OP_ANDI:  ctrl = reg_imm(ctrl, ALU_AND, SEL_LOGIC, {16'h0, inst_i[15:0]});
			OP_ORI:   ctrl = reg_imm(ctrl, ALU_OR, SEL_LOGIC, {16'h0, inst_i[15:0]});
			OP_XORI:  ctrl = reg_imm(ctrl, ALU_XOR, SEL_LOGIC, {16'h0, inst_i[15:0]});
			OP_LUI:   ctrl = reg_imm(ctrl, ALU_OR, SEL_LOGIC, {inst_i[15:0], 16'h0});	// rs is r0
			OP_LW: begin
				ctrl         = reg_imm(ctrl, ALU_LW, SEL_LOAD_STORE, '0);
			end
			OP_SW: begin
				ctrl.alu_op  = ALU_SW;
				ctrl.alu_sel = SEL_LOAD_STORE;
				ctrl.rs_read = 1'b1;	// base
				ctrl.rt_read = 1'b1;	// store data
				ctrl.valid   = 1'b1;
			end
			OP_COP0: begin
				// only eret survives in this core
				if (inst_i == ERET_WORD) begin
					ctrl.alu_op  = ALU_ERET;
					ctrl.is_eret = 1'b1;
					ctrl.valid   = 1'b1;
				end
			end
			default: ;
		endcase
	end

	assign ctrl_o      = ctrl;
	assign link_addr_o = ctrl.link ? pc_i + (INST_BYTES << 1) : '0;	// return past delay slot

endmodule

// File: src/operand_fwd.sv
`timescale 1ns/1ps

module operand_fwd import mips_pkg::*; (
	input  logic      read_i,
	input  reg_addr_t addr_i,
	input  word_t     rf_data_i,
	input  word_t     imm_i,
	fwd_src_if.sink   ex,
	fwd_src_if.sink   mem,
	output word_t     operand_o,
	output logic      load_stall_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex.wreg && (ex.wd == addr_i);
	assign mem_hit = mem.wreg && (mem.wd == addr_i);

	// load data is not ready until mem, so hold decode one cycle
	assign load_stall_o = read_i && (ex.alu_op == ALU_LW) && (ex.wd == addr_i);

	//////////////////////////////////////////////////
	// operand select, newest result wins
	//////////////////////////////////////////////////
	always_comb begin
		if (!read_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex.wdata;
		end else if (mem_hit) begin
			operand_o = mem.wdata;
		end else begin
			operand_o = rf_data_i;	// plain register file read
		end
	end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import mips_pkg::*; (
	input  dec_ctrl_t ctrl_i,
	input  word_t     pc_i,
	input  word_t     inst_i,
	input  word_t     reg1_i,
	input  word_t     reg2_i,
	output logic      branch_flag_o,
	output word_t     branch_target_o,
	output logic      next_in_delay_slot_o
);

	word_t pc_plus_4;
	word_t br_offset;
	word_t jump_target;
	word_t br_target;
	logic  taken;

	assign pc_plus_4   = pc_i + INST_BYTES;
	assign br_offset   = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};	// stays in the 256MB region
	assign br_target   = pc_plus_4 + br_offset;

	always_comb begin
		taken           = 1'b0;
		branch_target_o = '0;
		case (ctrl_i.br_kind)
			BR_JUMP_IMM: begin
				taken           = 1'b1;
				branch_target_o = jump_target;
			end
			BR_JUMP_REG: begin
				taken           = 1'b1;
				branch_target_o = reg1_i;
			end
			BR_EQ: begin
				taken           = (reg1_i == reg2_i);
				branch_target_o = br_target;
			end
			BR_NE: begin
				taken           = (reg1_i != reg2_i);
				branch_target_o = br_target;
			end
			BR_GTZ: begin
				taken           = !reg1_i[31] && (reg1_i != '0);
				branch_target_o = br_target;
			end
			BR_LEZ: begin
				taken           = reg1_i[31] || (reg1_i == '0);
				branch_target_o = br_target;
			end
			BR_GEZ: begin
				taken           = !reg1_i[31];
				branch_target_o = br_target;
			end
			BR_LTZ: begin
				taken           = reg1_i[31];
				branch_target_o = br_target;
			end
			default: ;
		endcase
	end

	assign branch_flag_o        = taken;
	assign next_in_delay_slot_o = taken;	// instruction after a taken branch

endmodule

// File: src/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg import mips_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  logic       stall_i,
	input  ex_bundle_t bundle_i,
	output ex_bundle_t bundle_o
);

	logic bubble;

	assign bubble = rst_i || stall_i;

	always_ff @(posedge clk) begin
		// datapath fields load every cycle
		bundle_o.reg1      <= bundle_i.reg1;
		bundle_o.reg2      <= bundle_i.reg2;
		bundle_o.wd        <= bundle_i.wd;
		bundle_o.link_addr <= bundle_i.link_addr;
		bundle_o.inst      <= bundle_i.inst;

		//////////////////////////////////////////////////
		// control fields
		//////////////////////////////////////////////////
		if (bubble) begin
			bundle_o.alu_op        <= ALU_NOP;
			bundle_o.alu_sel       <= SEL_NOP;
			bundle_o.wreg          <= 1'b0;
			bundle_o.in_delay_slot <= 1'b0;
			bundle_o.except        <= '0;
		end else begin
			bundle_o.alu_op        <= bundle_i.alu_op;
			bundle_o.alu_sel       <= bundle_i.alu_sel;
			bundle_o.wreg          <= bundle_i.wreg;
			bundle_o.in_delay_slot <= bundle_i.in_delay_slot;
			bundle_o.except        <= bundle_i.except;
		end
	end

endmodule

// File: src/id_stage.sv
`timescale 1ns/1ps

module id_stage import mips_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  word_t     pc_i,
	input  word_t     inst_i,
	input  word_t     rf_rdata1_i,
	input  word_t     rf_rdata2_i,
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  alu_op_e   ex_alu_op_i,
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	input  logic      in_delay_slot_i,
	output reg_addr_t rs_addr_o,
	output reg_addr_t rt_addr_o,
	output logic      stall_o,
	output logic      branch_flag_o,
	output word_t     branch_target_o,
	output logic      next_in_delay_slot_o,
	output alu_op_e   ex_alu_op_o,
	output alu_sel_e  ex_alu_sel_o,
	output word_t     ex_reg1_o,
	output word_t     ex_reg2_o,
	output reg_addr_t ex_wd_o,
	output logic      ex_wreg_o,
	output word_t     ex_link_addr_o,
	output logic      ex_in_delay_slot_o,
	output word_t     ex_inst_o,
	output except_t   ex_except_o
);

	dec_ctrl_t  ctrl;
	word_t      link_addr;
	word_t      reg1;
	word_t      reg2;
	logic       rs_stall;
	logic       rt_stall;
	except_t    except;
	ex_bundle_t ex_in;
	ex_bundle_t ex_out;

	fwd_src_if ex_fwd ();
	fwd_src_if mem_fwd ();

	assign ex_fwd.wreg    = ex_wreg_i;
	assign ex_fwd.wd      = ex_wd_i;
	assign ex_fwd.wdata   = ex_wdata_i;
	assign ex_fwd.alu_op  = ex_alu_op_i;
	assign mem_fwd.wreg   = mem_wreg_i;
	assign mem_fwd.wd     = mem_wd_i;
	assign mem_fwd.wdata  = mem_wdata_i;
	assign mem_fwd.alu_op = ALU_NOP;	// load check only looks at execute

	inst_decoder u_dec (.inst_i(inst_i), .pc_i(pc_i), .ctrl_o(ctrl), .link_addr_o(link_addr));

	operand_fwd u_rs_fwd (
		.read_i(ctrl.rs_read), .addr_i(ctrl.rs_addr), .rf_data_i(rf_rdata1_i),
		.imm_i(ctrl.imm), .ex(ex_fwd.sink), .mem(mem_fwd.sink),
		.operand_o(reg1), .load_stall_o(rs_stall)
	);

	operand_fwd u_rt_fwd (
		.read_i(ctrl.rt_read), .addr_i(ctrl.rt_addr), .rf_data_i(rf_rdata2_i),
		.imm_i(ctrl.imm), .ex(ex_fwd.sink), .mem(mem_fwd.sink),
		.operand_o(reg2), .load_stall_o(rt_stall)
	);

	branch_unit u_br (
		.ctrl_i(ctrl), .pc_i(pc_i), .inst_i(inst_i), .reg1_i(reg1), .reg2_i(reg2),
		.branch_flag_o(branch_flag_o), .branch_target_o(branch_target_o),
		.next_in_delay_slot_o(next_in_delay_slot_o)
	);

	assign rs_addr_o = ctrl.rs_addr;
	assign rt_addr_o = ctrl.rt_addr;
	assign stall_o   = rs_stall | rt_stall;

	assign except = '{syscall: ctrl.is_syscall, invalid: ~ctrl.valid, eret: ctrl.is_eret,
		default: '0};

	assign ex_in = '{alu_op: ctrl.alu_op, alu_sel: ctrl.alu_sel, reg1: reg1, reg2: reg2,
		wd: ctrl.wd, wreg: ctrl.wreg, link_addr: link_addr, in_delay_slot: in_delay_slot_i,
		inst: inst_i, except: except};

	id_ex_reg u_id_ex (.clk(clk), .rst_i(rst_i), .stall_i(stall_o), .bundle_i(ex_in),
		.bundle_o(ex_out));

	assign ex_alu_op_o        = ex_out.alu_op;
	assign ex_alu_sel_o       = ex_out.alu_sel;
	assign ex_reg1_o          = ex_out.reg1;
	assign ex_reg2_o          = ex_out.reg2;
	assign ex_wd_o            = ex_out.wd;
	assign ex_wreg_o          = ex_out.wreg;
	assign ex_link_addr_o     = ex_out.link_addr;
	assign ex_in_delay_slot_o = ex_out.in_delay_slot;
	assign ex_inst_o          = ex_out.inst;
	assign ex_except_o        = ex_out.except;

endmodule

// File: dv/id_stage_sva.sv
`timescale 1ns/1ps

module id_stage_sva import mips_pkg::*; (
	input logic      clk,
	input logic      rst_i,
	input word_t     pc_i,
	input word_t     inst_i,
	input logic      stall_i,
	input alu_op_e   alu_op_i,
	input logic      wreg_i,
	input reg_addr_t wd_i,
	input word_t     link_addr_i,
	input word_t     except_i
);

	localparam logic [5:0] JAL_OP      = 6'b000011;
	localparam word_t      EXCEPT_BITS = 32'h0000_1300;	// syscall, invalid, eret

	int fail_cnt = 0;

	//////////////////////////////////////////////////
	// register behaviour
	//////////////////////////////////////////////////
	reset_bubble: assert property (@(posedge clk)
		$fell(rst_i) |-> (alu_op_i == ALU_NOP) && !wreg_i && (except_i == '0))
	else begin
		$error("first cycle after reset is not a bubble");
		fail_cnt++;
	end

	// a stall request turns the next cycle into a bubble
	stall_bubble: assert property (@(posedge clk) disable iff (rst_i)
		stall_i |=> (alu_op_i == ALU_NOP) && !wreg_i && (except_i == '0))
	else begin
		$error("stall was not followed by a bubble");
		fail_cnt++;
	end

	except_onehot: assert property (@(posedge clk) disable iff (rst_i)
		((except_i & ~EXCEPT_BITS) == '0) && $onehot0(except_i & EXCEPT_BITS))
	else begin
		$error("exception word has stray or multiple bits");
		fail_cnt++;
	end

	// jal links pc+8 into r31
	jal_link: assert property (@(posedge clk) disable iff (rst_i)
		((inst_i[31:26] == JAL_OP) && !stall_i) |=>
			wreg_i && (wd_i == 5'd31) && (link_addr_i == $past(pc_i) + 32'd8))
	else begin
		$error("jal did not produce the link register write");
		fail_cnt++;
	end

endmodule

bind id_stage id_stage_sva u_sva (
	.clk(clk),
	.rst_i(rst_i),
	.pc_i(pc_i),
	.inst_i(inst_i),
	.stall_i(stall_o),
	.alu_op_i(ex_alu_op_o),
	.wreg_i(ex_wreg_o),
	.wd_i(ex_wd_o),
	.link_addr_i(ex_link_addr_o),
	.except_i(ex_except_o)
);

// File: dv/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb import mips_pkg::*; ();

	localparam logic [31:0] SEED = 32'hddbb869d;
	// cycle budget per test in run order
	localparam int TEST_CYCLES    = 10 + 6 + 6 + 4 + 6 + 6;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic      clk = 1'b0;
	logic      rst_i;
	word_t     pc_i;
	word_t     inst_i;
	word_t     rf_rdata1_i;
	word_t     rf_rdata2_i;
	logic      ex_wreg_i;
	reg_addr_t ex_wd_i;
	word_t     ex_wdata_i;
	alu_op_e   ex_alu_op_i;
	logic      mem_wreg_i;
	reg_addr_t mem_wd_i;
	word_t     mem_wdata_i;
	logic      in_delay_slot_i;
	reg_addr_t rs_addr_o;
	reg_addr_t rt_addr_o;
	logic      stall_o;
	logic      branch_flag_o;
	word_t     branch_target_o;
	logic      next_in_delay_slot_o;
	alu_op_e   ex_alu_op_o;
	alu_sel_e  ex_alu_sel_o;
	word_t     ex_reg1_o;
	word_t     ex_reg2_o;
	reg_addr_t ex_wd_o;
	logic      ex_wreg_o;
	word_t     ex_link_addr_o;
	logic      ex_in_delay_slot_o;
	word_t     ex_inst_o;
	except_t   ex_except_o;

	string cur_test;
	int    test_errors = 0;
	int    pass_cnt = 0;
	int    fail_cnt = 0;
	int    cycle_cnt = 0;

	id_stage DUT (.*);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// encoding and checking helpers
	//////////////////////////////////////////////////
	function automatic word_t r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
			reg_addr_t sa, logic [5:0] fn);
		return {6'b000000, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_type(logic [5:0] op, logic [25:0] idx);
		return {op, idx};
	endfunction

	// pc+4 plus word offset
	function automatic word_t br_target(word_t pc, logic [15:0] off);
		return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			pass_cnt++;
			$display("%s: ok", cur_test);
		end else begin
			fail_cnt++;
			$display("%s: %0d errors", cur_test, test_errors);
		end
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////
	task automatic reset_bubble();
		start_test("reset");
		repeat (8) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);	// register still holds the reset load
		expect_eq("alu_op", ALU_NOP, ex_alu_op_o);
		expect_eq("wreg", 1'b0, ex_wreg_o);
		expect_eq("except", '0, ex_except_o);
		expect_eq("delay slot", 1'b0, ex_in_delay_slot_o);
		end_test();
	endtask

	task automatic imm_case(input string what, input word_t inst, input word_t exp,
			input reg_addr_t rt, input alu_sel_e sel);
		@(posedge clk);
		inst_i <= inst;
		@(negedge clk);
		@(negedge clk);
		expect_eq({what, " reg2"}, exp, ex_reg2_o);
		expect_eq({what, " wd"}, rt, ex_wd_o);
		expect_eq({what, " wreg"}, 1'b1, ex_wreg_o);
		expect_eq({what, " alu_sel"}, sel, ex_alu_sel_o);
		expect_eq({what, " inst"}, inst, ex_inst_o);
	endtask

	task automatic immediate_forms();
		logic [15:0] imm;
		start_test("immediates");
		imm = 16'($urandom);
		imm_case("ori", i_type(OP_ORI, 5'd3, 5'd5, imm), {16'h0, imm}, 5'd5, SEL_LOGIC);
		imm = 16'($urandom) | 16'h8000;	// negative, so the extension shows
		imm_case("addiu", i_type(OP_ADDIU, 5'd3, 5'd6, imm), {{16{imm[15]}}, imm}, 5'd6,
			SEL_ARITH);
		imm = 16'($urandom);
		imm_case("lui", i_type(OP_LUI, 5'd0, 5'd7, imm), {imm, 16'h0}, 5'd7, SEL_LOGIC);
		end_test();
	endtask

	task automatic fwd_case(input string what, input logic ex_hit, input logic mem_hit);
		word_t ex_data;
		word_t mem_data;
		word_t rf_data;
		word_t exp;
		ex_data  = $urandom;
		mem_data = $urandom;
		rf_data  = $urandom;
		exp      = ex_hit ? ex_data : (mem_hit ? mem_data : rf_data);
		@(posedge clk);
		inst_i      <= r_type(5'd9, 5'd10, 5'd4, 5'd0, FN_ADDU);
		rf_rdata1_i <= rf_data;
		ex_wreg_i   <= 1'b1;
		ex_wd_i     <= ex_hit ? 5'd9 : 5'd12;
		ex_wdata_i  <= ex_data;
		mem_wreg_i  <= 1'b1;
		mem_wd_i    <= mem_hit ? 5'd9 : 5'd13;
		mem_wdata_i <= mem_data;
		@(negedge clk);
		expect_eq({what, " rs addr"}, 5'd9, rs_addr_o);
		expect_eq({what, " rt addr"}, 5'd10, rt_addr_o);
		@(negedge clk);
		expect_eq(what, exp, ex_reg1_o);
	endtask

	task automatic forwarding();
		start_test("forwarding");
		fwd_case("ex and mem hit", 1'b1, 1'b1);
		fwd_case("mem hit", 1'b0, 1'b1);
		fwd_case("no hit", 1'b0, 1'b0);
		end_test();
	endtask

	task automatic stall_case(input string what, input reg_addr_t load_dst);
		@(posedge clk);
		inst_i      <= r_type(5'd9, 5'd10, 5'd4, 5'd0, FN_ADDU);
		ex_alu_op_i <= ALU_LW;
		ex_wreg_i   <= 1'b1;
		ex_wd_i     <= load_dst;
		mem_wreg_i  <= 1'b0;
		@(negedge clk);
		expect_eq({what, " stall"}, 1'b1, stall_o);
		@(negedge clk);
		expect_eq({what, " alu_op"}, ALU_NOP, ex_alu_op_o);
		expect_eq({what, " wreg"}, 1'b0, ex_wreg_o);
		expect_eq({what, " except"}, '0, ex_except_o);
	endtask

	task automatic load_use();
		start_test("load_use");
		stall_case("rs", 5'd9);
		stall_case("rt", 5'd10);
		end_test();
	endtask

	task automatic branches();
		word_t       pc;
		word_t       pc4;
		word_t       a;
		logic [15:0] off;
		logic [25:0] idx;
		start_test("branches");
		pc  = $urandom & 32'hffff_fffc;
		pc4 = pc + 32'd4;
		off = 16'($urandom);
		a   = $urandom;
		@(posedge clk);
		ex_alu_op_i <= ALU_NOP;	// nothing in flight
		ex_wreg_i   <= 1'b0;
		mem_wreg_i  <= 1'b0;
		inst_i      <= i_type(OP_BEQ, 5'd1, 5'd2, off);
		pc_i        <= pc;
		rf_rdata1_i <= a;
		rf_rdata2_i <= a;
		@(negedge clk);
		expect_eq("beq flag", 1'b1, branch_flag_o);
		expect_eq("beq target", br_target(pc, off), branch_target_o);
		expect_eq("beq delay slot", 1'b1, next_in_delay_slot_o);
		@(posedge clk);
		inst_i          <= i_type(OP_BNE, 5'd1, 5'd2, off);
		rf_rdata2_i     <= a ^ 32'h1;
		in_delay_slot_i <= 1'b1;
		@(negedge clk);
		expect_eq("bne flag", 1'b1, branch_flag_o);
		expect_eq("bne target", br_target(pc, off), branch_target_o);
		@(negedge clk);
		expect_eq("bne in delay slot", 1'b1, ex_in_delay_slot_o);
		idx = 26'($urandom);
		@(posedge clk);
		inst_i          <= j_type(OP_JAL, idx);
		in_delay_slot_i <= 1'b0;
		@(negedge clk);
		expect_eq("jal flag", 1'b1, branch_flag_o);
		expect_eq("jal target", {pc4[31:28], idx, 2'b00}, branch_target_o);
		@(negedge clk);
		expect_eq("jal wd", 5'd31, ex_wd_o);
		expect_eq("jal wreg", 1'b1, ex_wreg_o);
		expect_eq("jal link", pc + 32'd8, ex_link_addr_o);
		end_test();
	endtask

	task automatic except_case(input string what, input word_t inst, input word_t exp);
		@(posedge clk);
		inst_i <= inst;
		@(negedge clk);
		@(negedge clk);
		expect_eq(what, exp, ex_except_o);
	endtask

	task automatic exceptions();
		start_test("exceptions");
		except_case("syscall", r_type(5'd0, 5'd0, 5'd0, 5'd0, 6'b001100), 32'h0000_0100);
		except_case("unused opcode", {6'b111111, 26'h0}, 32'h0000_0200);
		except_case("eret", {6'b010000, 1'b1, 19'd0, 6'b011000}, 32'h0000_1000);
		end_test();
	endtask

	//////////////////////////////////////////////////
	// run
	//////////////////////////////////////////////////
	initial begin
		void'($urandom(SEED));
		rst_i           <= 1'b1;
		pc_i            <= '0;
		inst_i          <= '0;
		rf_rdata1_i     <= '0;
		rf_rdata2_i     <= '0;
		ex_wreg_i       <= 1'b0;
		ex_wd_i         <= '0;
		ex_wdata_i      <= '0;
		ex_alu_op_i     <= ALU_NOP;
		mem_wreg_i      <= 1'b0;
		mem_wd_i        <= '0;
		mem_wdata_i     <= '0;
		in_delay_slot_i <= 1'b0;

		reset_bubble();
		immediate_forms();
		forwarding();
		load_use();
		branches();
		exceptions();

		$display("tests passed: %0d, failed: %0d, assertion failures: %0d",
			pass_cnt, fail_cnt, DUT.u_sva.fail_cnt);
		if (fail_cnt == 0 && DUT.u_sva.fail_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: mips_id.f
src/mips_pkg.sv
src/fwd_src_if.sv
src/inst_decoder.sv
src/operand_fwd.sv
src/branch_unit.sv
src/id_ex_reg.sv
src/id_stage.sv
dv/id_stage_sva.sv
dv/id_stage_tb.sv

// File: Bender.yml
package:
  name: mips_id

sources:
  - src/mips_pkg.sv
  - src/fwd_src_if.sv
  - src/inst_decoder.sv
  - src/operand_fwd.sv
  - src/branch_unit.sv
  - src/id_ex_reg.sv
  - src/id_stage.sv
  - target: test
    files:
      - dv/id_stage_sva.sv
      - dv/id_stage_tb.sv
